// ==== design/uart_byte_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_byte_rx #(
  parameter int clks_per_bit = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output uart_pkg::uart_byte_t read_data,
  output logic                 read_vld,
  output logic                 rx_err
);

  import uart_pkg::*;

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  typedef logic [cnt_w-1:0] baud_cnt_t;

  localparam baud_cnt_t last_cnt = baud_cnt_t'(clks_per_bit - 1);
  // counter starts one edge after the synchronized line fell
  localparam baud_cnt_t mid_cnt  = baud_cnt_t'(clks_per_bit / 2 - 1);

  rx_state_t   state;
  baud_cnt_t   baud_cnt;
  bit_cnt_t    bit_pos;
  uart_frame_t frame_q;
  uart_frame_t frame_next;
  logic        sync_1;
  logic        sync_2;
  logic        edge_q;
  logic        start_fall;
  logic        mid_bit;
  logic        frame_ok;

  // two flop synchronizer plus one stage for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_1 <= idle_level;
      sync_2 <= idle_level;
      edge_q <= idle_level;
    end else begin
      sync_1 <= rx;
      sync_2 <= sync_1;
      edge_q <= sync_2;
    end
  end

  assign start_fall = edge_q && !sync_2;
  assign mid_bit    = (baud_cnt == mid_cnt);

  // samples enter from the top, so the start bit ends up at index 0
  assign frame_next = uart_frame_t'({sync_2, frame_q[frame_bits-1:1]});

  always_ff @(posedge clk) begin
    if (state == rx_frame && mid_bit) begin
      frame_q <= frame_next;
    end
  end

  // odd count of ones over data and parity, and a high stop bit
  assign frame_ok = (^{frame_next.data, frame_next.parity}) && frame_next.stop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= rx_idle;
      baud_cnt  <= '0;
      bit_pos   <= '0;
      read_data <= '0;
      read_vld  <= 1'b0;
      rx_err    <= 1'b0;
    end else begin
      read_vld <= 1'b0;
      rx_err   <= 1'b0;
      case (state)
        rx_idle: begin
          if (start_fall) begin
            state    <= rx_frame;
            baud_cnt <= '0;
            bit_pos  <= '0;
          end
        end

        rx_frame: begin
          if (baud_cnt == last_cnt) begin
            baud_cnt <= '0;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
          if (mid_bit) begin
            if (bit_pos == stop_pos) begin
              // result at the stop sample, idle again right after
              state     <= rx_idle;
              read_data <= frame_next.data;
              read_vld  <= frame_ok;
              rx_err    <= !frame_ok;
            end else begin
              bit_pos <= bit_pos + 1'b1;
            end
          end
        end

        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_cmd_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::uart_cmd_t cmd,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output logic                tx
);

  import uart_pkg::*;

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  typedef logic [cnt_w-1:0] baud_cnt_t;

  localparam baud_cnt_t last_cnt = baud_cnt_t'(clks_per_bit - 1);

  tx_state_t   state;
  baud_cnt_t   baud_cnt;
  bit_cnt_t    bit_pos;
  bit_cnt_t    next_pos;
  uart_cmd_t   cmd_q;
  uart_byte_t  cur_byte;
  uart_frame_t cur_frame;
  logic        cmd_take;
  logic        write_cmd;
  logic        bit_end;
  logic        frame_end;

  // ready only while nothing is on the line
  assign cmd_rdy  = (state == tx_idle);
  assign cmd_take = cmd_vld && cmd_rdy;

  // stored copy of the accepted command
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      cmd_q <= cmd;
    end
  end

  assign write_cmd = cmd_q.hi[7];

  // address byte goes first, data byte only for writes
  assign cur_byte = (state == tx_low) ? cmd_q.lo : cmd_q.hi;

  // odd parity over data plus parity bit
  assign cur_frame = '{
    stop:   stop_level,
    parity: ~^cur_byte,
    data:   cur_byte,
    start:  start_level
  };

  assign bit_end   = (baud_cnt == last_cnt);
  assign frame_end = (bit_pos == stop_pos);
  assign next_pos  = bit_pos + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= tx_idle;
      baud_cnt <= '0;
      bit_pos  <= '0;
      tx       <= idle_level;
    end else begin
      case (state)
        tx_idle: begin
          // start bit goes out on the accepting edge
          if (cmd_take) begin
            state    <= tx_high;
            baud_cnt <= '0;
            bit_pos  <= '0;
            tx       <= start_level;
          end
        end

        tx_high, tx_low: begin
          if (bit_end) begin
            baud_cnt <= '0;
            if (frame_end) begin
              if (state == tx_high && write_cmd) begin
                // data frame follows back to back
                state   <= tx_low;
                bit_pos <= '0;
                tx      <= start_level;
              end else begin
                state <= tx_idle;
                tx    <= idle_level;
              end
            end else begin
              bit_pos <= next_pos;
              tx      <= cur_frame[next_pos];
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        default: begin
          state <= tx_idle;
          tx    <= idle_level;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/uart_link.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_link #(
  parameter int clks_per_bit = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // command side
  input  uart_pkg::uart_cmd_t  cmd,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,

  // serial line
  output logic                 tx,
  input  logic                 rx,

  // read answer
  output uart_pkg::uart_byte_t read_data,
  output logic                 read_vld,
  output logic                 rx_err
);

  // transmit and receive paths share only clock and reset
  uart_cmd_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_cmd_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .tx      (tx)
  );

  uart_byte_rx #(
    .clks_per_bit (clks_per_bit)
  ) u_byte_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_vld  (read_vld),
    .rx_err    (rx_err)
  );

endmodule

`default_nettype wire

// ==== design/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // one data byte on the line, also the read result
  typedef logic [7:0] uart_byte_t;

  // position inside a frame, 0 is the start bit and 10 the stop bit
  typedef logic [3:0] bit_cnt_t;

  // command word; bit 7 of the high byte is the write flag
  typedef struct packed {
    uart_byte_t hi;
    uart_byte_t lo;
  } uart_cmd_t;

  // one frame as it appears on the line, start bit at index 0
  typedef struct packed {
    logic       stop;
    logic       parity;
    uart_byte_t data;
    logic       start;
  } uart_frame_t;

  localparam int frame_bits = 11;

  localparam bit_cnt_t stop_pos = bit_cnt_t'(frame_bits - 1);

  localparam logic start_level = 1'b0;
  localparam logic stop_level  = 1'b1;
  // line rests at the stop level between frames
  localparam logic idle_level  = stop_level;

  typedef enum logic [1:0] {
    tx_idle,
    tx_high,
    tx_low
  } tx_state_t;

  typedef enum logic {
    rx_idle,
    rx_frame
  } rx_state_t;

endpackage

`default_nettype wire

// ==== filelist.f ====
design/uart_pkg.sv
design/uart_cmd_tx.sv
design/uart_byte_rx.sv
design/uart_link.sv
verification/clk_gen.sv
verification/uart_link_properties.sv
verification/tb_uart_link.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_uart_link -f filelist.f -o tb_uart_link

./obj_dir/tb_uart_link | tee sim.log

if grep -qx 'TEST OK' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed" >&2
  exit 1
fi

// ==== verification/clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
  parameter int half_period = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== verification/tb_uart_link.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_uart_link;

  import uart_pkg::*;

  localparam int clks_per_bit   = 8;
  localparam int num_cmds       = 40;
  localparam int num_frames     = 40;
  localparam int drive_delay    = 2;
  localparam int rx_latency     = 10 * clks_per_bit + clks_per_bit / 2 + 3;
  localparam int timeout_cycles =
    num_cmds * 22 * clks_per_bit + num_frames * 12 * clks_per_bit + 2000;

  // one frame put on rx and the result it should give
  typedef struct packed {
    uart_byte_t  data;
    logic        good;
    int unsigned start_cycle;
  } rx_expect_t;

  logic        clk;
  logic        rst_n;
  uart_cmd_t   cmd;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        tx;
  logic        rx;
  uart_byte_t  read_data;
  logic        read_vld;
  logic        rx_err;
  int unsigned cycle = 0;
  int          checks = 0;
  int          errors = 0;
  uart_byte_t  exp_tx_q[$];
  rx_expect_t  rx_expect_q[$];

  clk_gen u_clk_gen (.clk(clk));

  uart_link #(
    .clks_per_bit (clks_per_bit)
  ) u_uart_link (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_data (read_data),
    .read_vld  (read_vld),
    .rx_err    (rx_err)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic check_byte(string name, uart_byte_t got, uart_byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_cycles(string name, int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail %s: got 0x%0h cycles, expected 0x%0h", name, got, exp);
    end
  endtask

  // parity bit that leaves an odd count of ones
  function automatic logic odd_parity(uart_byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += b[i];
    end
    return (ones % 2 == 0);
  endfunction

  task automatic issue_commands();
    uart_cmd_t   c;
    int unsigned accept_cycle;
    for (int n = 0; n < num_cmds; n++) begin
      repeat ($urandom_range(0, 12)) next_cycle();
      while (cmd_rdy !== 1'b1) next_cycle();
      c.hi = uart_byte_t'($urandom_range(0, 255));
      c.lo = uart_byte_t'($urandom_range(0, 255));
      cmd = c;
      cmd_vld = 1'b1;
      next_cycle();
      accept_cycle = cycle;
      cmd_vld = 1'b0;
      check_bit("cmd_rdy", cmd_rdy, 1'b0);
      // address always, data byte only on a write
      exp_tx_q.push_back(c.hi);
      if (c[15]) begin
        exp_tx_q.push_back(c.lo);
      end
      // strobe while busy must be ignored
      if ($urandom_range(0, 3) == 0) begin
        repeat ($urandom_range(1, 20)) next_cycle();
        cmd = uart_cmd_t'(16'hffff ^ c);
        cmd_vld = 1'b1;
        next_cycle();
        cmd_vld = 1'b0;
      end
      while (cmd_rdy !== 1'b1) next_cycle();
      check_cycles("cmd_rdy delay", int'(cycle - accept_cycle),
                   (c[15] ? 22 : 11) * clks_per_bit);
      check_bit("tx", tx, 1'b1);
    end
  endtask

  task automatic send_rx_frames();
    uart_frame_t f;
    rx_expect_t  e;
    int          kind;
    for (int n = 0; n < num_frames; n++) begin
      rx = 1'b1;
      repeat ($urandom_range(2, 12)) next_cycle();
      f.start  = 1'b0;
      f.data   = uart_byte_t'($urandom_range(0, 255));
      f.parity = odd_parity(f.data);
      f.stop   = 1'b1;
      // two kinds of damage in ten
      kind = $urandom_range(0, 9);
      if (kind == 0) begin
        f.parity = ~f.parity;
      end else if (kind == 1) begin
        f.stop = 1'b0;
      end
      e.data = f.data;
      e.good = (kind > 1);
      e.start_cycle = cycle;
      rx_expect_q.push_back(e);
      for (int i = 0; i < frame_bits; i++) begin
        rx = f[i];
        repeat (clks_per_bit) next_cycle();
      end
    end
    rx = 1'b1;
  endtask

  // tx line model, samples each bit at its middle
  initial begin
    uart_frame_t got;
    forever begin
      next_cycle();
      if (tx === 1'b0) begin
        repeat (clks_per_bit / 2) next_cycle();
        got[0] = tx;
        for (int i = 1; i < frame_bits; i++) begin
          repeat (clks_per_bit) next_cycle();
          got[i] = tx;
        end
        check_bit("tx start", got.start, 1'b0);
        check_bit("tx parity", got.parity, odd_parity(got.data));
        check_bit("tx stop", got.stop, 1'b1);
        if (exp_tx_q.size() == 0) begin
          errors++;
          $display("frame 0x%02h on tx with no command pending", got.data);
        end else begin
          check_byte("tx data", got.data, exp_tx_q.pop_front());
        end
      end
    end
  end

  initial begin
    rx_expect_t e;
    forever begin
      next_cycle();
      if (read_vld === 1'b1 || rx_err === 1'b1) begin
        if (rx_expect_q.size() == 0) begin
          errors++;
          $display("receiver gave a result with no frame sent on rx");
        end else begin
          e = rx_expect_q.pop_front();
          check_cycles("rx latency", int'(cycle - e.start_cycle), rx_latency);
          check_bit("read_vld", read_vld, e.good);
          check_bit("rx_err", rx_err, !e.good);
          if (e.good) begin
            check_byte("read_data", read_data, e.data);
          end
        end
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the tests did not finish", timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'heb943fa6));
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (3) next_cycle();
    check_bit("tx", tx, 1'b1);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    check_bit("read_vld", read_vld, 1'b0);
    check_bit("rx_err", rx_err, 1'b0);
    check_byte("read_data", read_data, 8'h00);
    rst_n = 1'b1;
    repeat (4) next_cycle();
    fork
      issue_commands();
      send_rx_frames();
    join
    repeat (4 * clks_per_bit) next_cycle();
    if (exp_tx_q.size() != 0 || rx_expect_q.size() != 0) begin
      errors++;
      $display("%0d tx bytes and %0d rx results never showed up",
               exp_tx_q.size(), rx_expect_q.size());
    end
    errors += u_uart_link.u_link_properties.assert_fails;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/uart_link_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_link_properties #(
  parameter int clks_per_bit = 434
) (
  input logic clk,
  input logic rst_n,
  input logic cmd_rdy,
  input logic tx,
  input logic read_vld,
  input logic rx_err
);

  int busy_cnt;
  int assert_fails = 0;

  // cycles since the serializer left idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_cnt <= 0;
    end else if (cmd_rdy) begin
      busy_cnt <= 0;
    end else begin
      busy_cnt <= busy_cnt + 1;
    end
  end

  result_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_vld && rx_err))
  else begin
    assert_fails++;
    $error("read_vld and rx_err high in the same cycle");
  end

  // a read frame is the shortest busy time
  busy_min_time: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> busy_cnt >= 11 * clks_per_bit)
  else begin
    assert_fails++;
    $error("cmd_rdy rose after only %0d cycles", busy_cnt);
  end

  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
  else begin
    assert_fails++;
    $error("tx low while cmd_rdy is high");
  end

endmodule

bind uart_link uart_link_properties #(
  .clks_per_bit (clks_per_bit)
) u_link_properties (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_vld (read_vld),
  .rx_err   (rx_err)
);

`default_nettype wire
